// ==== Bender.yml ====
package:
  name: wb_writeback

sources:
  - design/isa_pkg.sv
  - design/csr_pkg.sv
  - design/wb_stage.sv
  - design/reg_file.sv
  - design/csr_file.sv
  - design/perf_counters.sv
  - design/wb_top.sv
  - target: test
    files:
      - tests/wb_chk.sv
      - tests/wb_tb.sv

// ==== design/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// Selects are expected one-hot; a zero select reads
// zero. Several set bits OR the chosen CSRs
//##################################################

module csr_file import isa_pkg::*, csr_pkg::*; (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire csr_wen_t wen,
    input  wire word_t    wdata,
    input  wire csr_wen_t rsel_a,
    input  wire csr_wen_t rsel_b,
    output word_t         rdata_a,
    output word_t         rdata_b
);

    word_t csrs [csr_count];

    always_ff @(posedge clock) begin
        if (reset) begin
            csrs[csr_mstatus] <= csr_reset_value[csr_mstatus];
            csrs[csr_mtvec] <= csr_reset_value[csr_mtvec];
            csrs[csr_mepc] <= csr_reset_value[csr_mepc];
            csrs[csr_mcause] <= csr_reset_value[csr_mcause];
        end else begin
            for (int i = 0; i < csr_count; i++) begin
                if (wen[i]) begin
                    csrs[i] <= wdata;
                end
            end
        end
    end

    // Read by one-hot select with bypass of the pending write
    function automatic word_t read_csr(
        input csr_wen_t sel,
        input csr_wen_t wr_en,
        input word_t    wr_data,
        input word_t    regs [csr_count]
    );
        word_t result;
        result = '0;
        for (int i = 0; i < csr_count; i++) begin
            if (sel[i]) begin
                result = result | (wr_en[i] ? wr_data : regs[i]);
            end
        end
        return result;
    endfunction

    always_comb begin
        rdata_a = read_csr(rsel_a, wen, wdata, csrs);
        rdata_b = read_csr(rsel_b, wen, wdata, csrs);
    end

endmodule

`default_nettype wire

// ==== design/csr_pkg.sv ====
`default_nettype none
//##################################################
// Only four machine CSRs, each owning one bit of a
// one-hot enable. No address decode lives here
//##################################################

package csr_pkg;

    import isa_pkg::*;

    localparam int unsigned csr_count = 4;

    // One-hot write enable, also used as read select
    typedef logic [csr_count-1:0] csr_wen_t;

    // Bit positions in csr_wen_t
    localparam int unsigned csr_mstatus = 0;
    localparam int unsigned csr_mtvec = 1;
    localparam int unsigned csr_mepc = 2;
    localparam int unsigned csr_mcause = 3;

    // Reset contents, indexed by the bit positions above
    localparam word_t csr_reset_value [csr_count] = '{
        32'h0000_0000,
        32'h0000_0100,
        32'h0000_0000,
        32'h0000_0000
    };

endpackage

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none
//##################################################
// RV32 only. Widths here are fixed by the ISA and
// must not be changed for a wider core
//##################################################

package isa_pkg;

    // Data path width
    localparam int unsigned xlen = 32;

    // Register index width and integer register count
    localparam int unsigned reg_addr_width = 5;
    localparam int unsigned reg_count = 32;

    // Data or address word
    typedef logic [xlen-1:0] word_t;

    // Integer register index, x0 to x31
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // Raw instruction word, no compressed encodings
    typedef logic [31:0] inst_t;

    // Return address step, pc plus this for a jump
    localparam word_t inst_bytes = 32'd4;

endpackage

`default_nettype wire

// ==== design/perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// Free-running 32-bit counters, wrap silently
//##################################################

module perf_counters import isa_pkg::*; (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic retire,
    input  wire logic load,
    output word_t     instret,
    output word_t     loadret
);

    always_ff @(posedge clock) begin
        if (reset) begin
            instret <= '0;
        end else if (retire) begin
            instret <= instret + 32'd1;
        end
    end

    // A load only counts when it actually retires
    always_ff @(posedge clock) begin
        if (reset) begin
            loadret <= '0;
        end else if (retire && load) begin
            loadret <= loadret + 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// x0 has no storage and always reads zero. Read
// port bypasses a write to the same address
//##################################################

module reg_file import isa_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      wen,
    input  wire reg_addr_t waddr,
    input  wire word_t     wdata,
    input  wire reg_addr_t raddr,
    output word_t          rdata
);

    word_t regs [1:reg_count-1];

    logic write_hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign write_hit = wen && (waddr == raddr);

    always_comb begin
        if (raddr == '0) begin
            rdata = '0;
        end else if (write_hit) begin
            // Same-cycle write wins over the stored value
            rdata = wdata;
        end else begin
            rdata = regs[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// Never stalls. Write enables are qualified by the
// registered valid, so held data cannot write again
//##################################################

module wb_stage import isa_pkg::*, csr_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      valid,
    input  wire word_t     pc,
    input  wire inst_t     inst,
    input  wire reg_addr_t rd,
    input  wire logic      rd_wen,
    input  wire logic      mem_ren,
    input  wire logic      jump_flag,
    input  wire csr_wen_t  csr_wen,
    input  wire word_t     mem_rdata,
    input  wire word_t     ex_result,
    input  wire word_t     csrs,
    output logic           valid_next,
    output word_t          pc_next,
    output inst_t          inst_next,
    output reg_addr_t      rd_next,
    output word_t          rd_value,
    output logic           rd_wen_next,
    output csr_wen_t       csr_wen_next,
    output word_t          csrd,
    output logic           mem_ren_next
);

    logic     rd_wen_q;
    logic     mem_ren_q;
    logic     jump_q;
    csr_wen_t csr_wen_q;
    word_t    mem_rdata_q;
    word_t    ex_result_q;
    word_t    csrs_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_next <= 1'b0;
            rd_wen_q <= 1'b0;
            mem_ren_q <= 1'b0;
            jump_q <= 1'b0;
            csr_wen_q <= '0;
        end else begin
            valid_next <= valid;
            if (valid) begin
                rd_wen_q <= rd_wen;
                mem_ren_q <= mem_ren;
                jump_q <= jump_flag;
                csr_wen_q <= csr_wen;
            end
        end
    end

    // Payload, only meaningful while valid_next is high
    always_ff @(posedge clock) begin
        if (valid) begin
            pc_next <= pc;
            inst_next <= inst;
            rd_next <= rd;
            mem_rdata_q <= mem_rdata;
            ex_result_q <= ex_result;
            csrs_q <= csrs;
        end
    end

    // Jump, then load, then CSR old value, then ALU
    always_comb begin
        if (jump_q) begin
            rd_value = pc_next + inst_bytes;
        end else if (mem_ren_q) begin
            rd_value = mem_rdata_q;
        end else if (csr_wen_q != '0) begin
            rd_value = csrs_q;
        end else begin
            rd_value = ex_result_q;
        end
    end

    assign rd_wen_next = rd_wen_q & valid_next;
    assign csr_wen_next = csr_wen_q & {$bits(csr_wen_t){valid_next}};
    assign mem_ren_next = mem_ren_q & valid_next;
    assign csrd = ex_result_q;

endmodule

`default_nettype wire

// ==== design/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// csr_sel must select the CSR of the offered
// instruction; rs_addr and csr_rsel only observe
//##################################################

module wb_top import isa_pkg::*, csr_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      valid,
    input  wire word_t     pc,
    input  wire inst_t     inst,
    input  wire reg_addr_t rd,
    input  wire logic      rd_wen,
    input  wire logic      mem_ren,
    input  wire logic      jump_flag,
    input  wire csr_wen_t  csr_wen,
    input  wire word_t     mem_rdata,
    input  wire word_t     ex_result,
    input  wire csr_wen_t  csr_sel,
    input  wire reg_addr_t rs_addr,
    input  wire csr_wen_t  csr_rsel,
    output logic           commit_valid,
    output word_t          commit_pc,
    output inst_t          commit_inst,
    output word_t          rs_data,
    output word_t          csr_rdata,
    output word_t          instret,
    output word_t          loadret
);

    word_t     csrs;
    reg_addr_t rd_next;
    word_t     rd_value;
    logic      rd_wen_next;
    csr_wen_t  csr_wen_next;
    word_t     csrd;
    logic      mem_ren_next;

    wb_stage wb_stage_i (
        .clock, .reset, .valid, .pc, .inst, .rd, .rd_wen, .mem_ren,
        .jump_flag, .csr_wen, .mem_rdata, .ex_result, .csrs,
        .valid_next(commit_valid), .pc_next(commit_pc), .inst_next(commit_inst),
        .rd_next, .rd_value, .rd_wen_next, .csr_wen_next, .csrd, .mem_ren_next
    );

    reg_file reg_file_i (
        .clock, .reset,
        .wen(rd_wen_next), .waddr(rd_next), .wdata(rd_value),
        .raddr(rs_addr), .rdata(rs_data)
    );

    // Port A feeds the old CSR value back into the stage
    csr_file csr_file_i (
        .clock, .reset,
        .wen(csr_wen_next), .wdata(csrd),
        .rsel_a(csr_sel), .rsel_b(csr_rsel),
        .rdata_a(csrs), .rdata_b(csr_rdata)
    );

    perf_counters perf_counters_i (
        .clock, .reset,
        .retire(commit_valid), .load(mem_ren_next),
        .instret, .loadret
    );

endmodule

`default_nettype wire

// ==== flist.f ====
design/isa_pkg.sv
design/csr_pkg.sv
design/wb_stage.sv
design/reg_file.sv
design/csr_file.sv
design/perf_counters.sv
design/wb_top.sv
tests/wb_chk.sv
tests/wb_tb.sv

// ==== tests/wb_chk.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// Bound into every wb_stage, sampled on the rising
// clock edge
//##################################################

module wb_chk import csr_pkg::*; (
    input wire logic     clock,
    input wire logic     reset,
    input wire logic     valid_next,
    input wire logic     rd_wen_next,
    input wire logic     mem_ren_next,
    input wire csr_wen_t csr_wen_next
);

    // Number of failed assertions
    int unsigned assert_failures = 0;

    reset_clears_valid: assert property (@(posedge clock) reset |=> !valid_next)
        else begin
            assert_failures++;
            $error("valid_next high in the cycle after reset");
        end

    // An idle commit slot must not write anything
    idle_writes_nothing: assert property (@(posedge clock) disable iff (reset)
        !valid_next |-> (!rd_wen_next && !mem_ren_next && csr_wen_next == '0))
        else begin
            assert_failures++;
            $error("write enable set while valid_next is low");
        end

    csr_wen_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(csr_wen_next))
        else begin
            assert_failures++;
            $error("csr_wen_next has more than one bit set");
        end

endmodule

bind wb_stage wb_chk wb_chk_i (
    .clock(clock),
    .reset(reset),
    .valid_next(valid_next),
    .rd_wen_next(rd_wen_next),
    .mem_ren_next(mem_ren_next),
    .csr_wen_next(csr_wen_next)
);

`default_nettype wire

// ==== tests/wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
//##################################################
// Random commits checked against an in-order model.
// CSR selects are one-hot, traps are not modeled
//##################################################

module wb_tb import isa_pkg::*, csr_pkg::*; ();

    localparam int unsigned reset_cycles = 10;
    localparam int unsigned offered_cycles = 400;
    // Reset plus offered cycles plus drain is about 415, so 600 leaves margin
    localparam int unsigned timeout_cycles = 600;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        inst_t     inst;
        reg_addr_t rs_addr;
        word_t     rs_data;
        csr_wen_t  csr_rsel;
        word_t     csr_rdata;
        word_t     instret;
        word_t     loadret;
    } expect_t;

    logic      clock, reset, valid, rd_wen, mem_ren, jump_flag;
    word_t     pc, mem_rdata, ex_result;
    inst_t     inst;
    reg_addr_t rd, rs_addr;
    csr_wen_t  csr_wen, csr_sel, csr_rsel;
    logic      commit_valid;
    word_t     commit_pc, rs_data, csr_rdata, instret, loadret;
    inst_t     commit_inst;

    word_t       model_regs [reg_count];
    word_t       model_csrs [csr_count];
    word_t       model_instret, model_loadret;
    logic [31:0] rng_state;
    int unsigned error_count;
    expect_t     expect_q [$];

    wb_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_inst(input string name, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // Applies one valid commit in program order and returns the rd value
    function automatic word_t retire_in_model(input logic jump, input logic load,
            input logic csr_write, input int unsigned csr_idx, input reg_addr_t dest,
            input logic dest_wen, input word_t pc_in, input word_t load_data, input word_t alu);
        word_t value;
        if (jump) begin
            value = pc_in + inst_bytes;
        end else if (load) begin
            value = load_data;
        end else if (csr_write) begin
            value = model_csrs[csr_idx];
        end else begin
            value = alu;
        end
        if (dest_wen && dest != '0) begin
            model_regs[dest] = value;
        end
        if (csr_write) begin
            model_csrs[csr_idx] = alu;
        end
        model_instret = model_instret + 32'd1;
        if (load) begin
            model_loadret = model_loadret + 32'd1;
        end
        return value;
    endfunction

    // Commit cycle is checked on the falling edge, away from updates
    initial begin : compare_commits
        expect_t e;
        forever begin
            @(negedge clock);
            if (expect_q.size() != 0) begin
                e = expect_q.pop_front();
                check_bit("commit_valid", e.valid, commit_valid);
                if (e.valid) begin
                    check_word("commit_pc", e.pc, commit_pc);
                    check_inst("commit_inst", e.inst, commit_inst);
                end
                check_word("rs_data", e.rs_data, rs_data);
                check_word("csr_rdata", e.csr_rdata, csr_rdata);
                check_word("instret", e.instret, instret);
                check_word("loadret", e.loadret, loadret);
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, the commit checks never finished", timeout_cycles);
        $display("errors: %0d, assertion failures: %0d", error_count,
            dut_i.wb_stage_i.wb_chk_i.assert_failures);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        expect_t     pend;
        logic [31:0] r_ctrl, r_pc, r_inst, r_mem, r_alu;
        logic        v, j, ld, cw, w;
        int unsigned cidx, oidx;
        reg_addr_t   dest, oaddr;
        word_t       pc_val, value;
        rng_state = 32'h753c_a98a;
        error_count = 0;
        model_instret = '0;
        model_loadret = '0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < csr_count; i++) begin
            model_csrs[i] = csr_reset_value[i];
        end
        reset = 1'b1;
        valid = 1'b0;
        pc = '0;
        inst = '0;
        rd = '0;
        rd_wen = 1'b0;
        mem_ren = 1'b0;
        jump_flag = 1'b0;
        csr_wen = '0;
        mem_rdata = '0;
        ex_result = '0;
        csr_sel = '0;
        rs_addr = '0;
        csr_rsel = '0;
        value = '0;
        // First look after reset reads x1 and mtvec
        pend = '0;
        pend.rs_addr = 5'd1;
        pend.csr_rsel = csr_wen_t'(1 << csr_mtvec);
        pend.csr_rdata = csr_reset_value[csr_mtvec];
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        for (int n = 0; n <= offered_cycles; n++) begin
            @(posedge clock);
            // Observation ports follow the instruction entering commit
            rs_addr <= pend.rs_addr;
            csr_rsel <= pend.csr_rsel;
            expect_q.push_back(pend);
            next_random(r_ctrl);
            next_random(r_pc);
            next_random(r_inst);
            next_random(r_mem);
            next_random(r_alu);
            v = (n < offered_cycles) && (r_ctrl[1:0] != 2'b00);
            j = r_ctrl[2] & r_ctrl[3];
            ld = r_ctrl[4] & r_ctrl[5];
            cw = r_ctrl[6];
            cidx = r_ctrl[9:8];
            w = r_ctrl[12:10] != 3'b000;
            dest = r_ctrl[17:13];
            oidx = r_ctrl[19:18];
            oaddr = r_ctrl[24:20];
            pc_val = {r_pc[31:2], 2'b00};
            pend.valid = v;
            pend.pc = pc_val;
            pend.inst = r_inst;
            pend.instret = model_instret;
            pend.loadret = model_loadret;
            if (v) begin
                value = retire_in_model(j, ld, cw, cidx, dest, w, pc_val, r_mem, r_alu);
            end
            pend.rs_addr = (v && w) ? dest : oaddr;
            pend.rs_data = (v && w) ? ((dest == '0) ? '0 : value) : model_regs[oaddr];
            if (v && cw) begin
                oidx = cidx;
            end
            pend.csr_rsel = csr_wen_t'(1 << oidx);
            pend.csr_rdata = model_csrs[oidx];
            valid <= v;
            pc <= pc_val;
            inst <= r_inst;
            rd <= dest;
            rd_wen <= w;
            mem_ren <= ld;
            jump_flag <= j;
            csr_wen <= cw ? csr_wen_t'(1 << cidx) : csr_wen_t'(0);
            csr_sel <= csr_wen_t'(1 << cidx);
            mem_rdata <= r_mem;
            ex_result <= r_alu;
        end
        while (expect_q.size() != 0) begin
            @(posedge clock);
        end
        $display("errors: %0d, assertion failures: %0d", error_count,
            dut_i.wb_stage_i.wb_chk_i.assert_failures);
        if (error_count == 0 && dut_i.wb_stage_i.wb_chk_i.assert_failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
